//--- include/la_defs.svh
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// number of entries in the circular sample memory, a power of two
`define LA_SAMPLE_DEPTH 64

// address bits of the sample memory
`define LA_ADDR_WIDTH $clog2(`LA_SAMPLE_DEPTH)

// width of the probe bus and of every stored sample
`define LA_PROBE_WIDTH 16

// host register bus
`define LA_REG_ADDR_WIDTH 3
`define LA_REG_DATA_WIDTH 16

`endif

//--- src/la_pkg.sv
`include "la_defs.svh"

package la_pkg;

    // capture controller state, also visible in the status register
    typedef enum logic [3:0] {
        IDLE             = 0,
        MOVE_TO_POSITION = 1,
        IN_POSITION      = 2,
        CAPTURING        = 3,
        CAPTURED         = 4
    } cap_state_t;

    typedef enum logic [0:0] {
        TRIG_EQUAL  = 0,
        TRIG_RISING = 1
    } trig_mode_t;

    // host register map
    typedef enum logic [`LA_REG_ADDR_WIDTH-1:0] {
        REG_CONTROL      = 0,
        REG_TRIG_MODE    = 1,
        REG_TRIG_MASK    = 2,
        REG_TRIG_VALUE   = 3,
        REG_TRIG_LOC     = 4,
        REG_STATUS       = 5,
        REG_SAMPLE_INDEX = 6,
        REG_SAMPLE_DATA  = 7
    } reg_addr_t;

endpackage

//--- src/la_ctrl_if.sv
`include "la_defs.svh"

interface la_ctrl_if;

    // requests and configuration from the register file
    logic                                 request_start;
    logic                                 request_stop;
    logic signed [`LA_REG_DATA_WIDTH-1:0] trigger_loc;

    // capture status back to the register file
    la_pkg::cap_state_t                   state;
    logic signed [`LA_REG_DATA_WIDTH-1:0] current_loc;
    // oldest sample of the window, base for the readback address
    logic [`LA_ADDR_WIDTH-1:0]            read_pointer;

    modport regs (
        output request_start,
        output request_stop,
        output trigger_loc,
        input  state,
        input  current_loc,
        input  read_pointer
    );

    modport ctrl (
        input  request_start,
        input  request_stop,
        input  trigger_loc,
        output state,
        output current_loc,
        output read_pointer
    );

endinterface

//--- src/la_trigger.sv
`include "la_defs.svh"

module la_trigger (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`LA_PROBE_WIDTH-1:0] probe,
    input  la_pkg::trig_mode_t         trig_mode,
    input  logic [`LA_PROBE_WIDTH-1:0] trig_mask,
    input  logic [`LA_PROBE_WIDTH-1:0] trig_value,
    output logic                       trig,
    output logic [`LA_PROBE_WIDTH-1:0] sample
);

    // current registered probe and the one before it
    logic [`LA_PROBE_WIDTH-1:0] cur_q;
    logic [`LA_PROBE_WIDTH-1:0] prev_q;

    // marks which of the two sample stages hold real data
    logic [1:0] valid_q;

    logic eq_hit;
    logic rise_hit;

    always_ff @(posedge clk) begin
        cur_q  <= probe;
        prev_q <= cur_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 2'b00;
        end else begin
            valid_q <= {valid_q[0], 1'b1};
        end
    end

    // masked equality on the newest sample
    assign eq_hit = ((cur_q ^ trig_value) & trig_mask) == '0;

    // any masked bit going from 0 to 1 between the last two samples
    assign rise_hit = |(cur_q & ~prev_q & trig_mask);

    always_comb begin
        trig = 1'b0;
        if (valid_q[0]) begin
            case (trig_mode)
                la_pkg::TRIG_EQUAL:  trig = eq_hit;
                la_pkg::TRIG_RISING: trig = rise_hit & valid_q[1];
                default:             trig = 1'b0;
            endcase
        end
    end

    // the controller writes one cycle after it sees trig, so the stored
    // stream comes from the previous-sample stage, which is the trigger
    // sample by then
    assign sample = prev_q;

endmodule

//--- src/la_controller.sv
`include "la_defs.svh"

module la_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    la_ctrl_if.ctrl                   ctrl,
    input  logic                      trig,
    output logic [`LA_ADDR_WIDTH-1:0] wr_addr,
    output logic                      wr_en
);

    localparam int DEPTH = `LA_SAMPLE_DEPTH;
    localparam int AW    = `LA_ADDR_WIDTH;
    localparam int DW    = `LA_REG_DATA_WIDTH;

    la_pkg::cap_state_t   state;
    logic signed [DW-1:0] current_loc;
    logic signed [DW-1:0] next_loc;

    // previous request levels for edge detection
    logic start_d;
    logic stop_d;
    logic start_edge;
    logic stop_edge;

    // registered buffer commands
    logic acquire;
    logic pop;
    logic clear;

    // pointers carry one extra bit so that full and empty differ
    logic [AW:0] write_pointer;
    logic [AW:0] read_pointer;
    logic [AW:0] fill;
    logic        full;

    assign start_edge = ctrl.request_start & ~start_d;
    assign stop_edge  = ctrl.request_stop & ~stop_d;
    assign next_loc   = current_loc + DW'(1);

    assign fill = write_pointer - read_pointer;
    assign full = (fill == (AW+1)'(DEPTH));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= la_pkg::IDLE;
            current_loc <= '0;
            start_d     <= 1'b0;
            stop_d      <= 1'b0;
            acquire     <= 1'b0;
            pop         <= 1'b0;
            clear       <= 1'b0;
        end else begin
            start_d <= ctrl.request_start;
            stop_d  <= ctrl.request_stop;
            acquire <= 1'b0;
            pop     <= 1'b0;
            clear   <= 1'b0;
            case (state)
                la_pkg::IDLE: begin
                    current_loc <= '0;
                    clear       <= 1'b1;
                    if (start_edge) begin
                        clear <= 1'b0;
                        // no pre-trigger samples wanted, start sliding at once
                        if (ctrl.trigger_loc <= 0) begin
                            state <= la_pkg::IN_POSITION;
                        end else begin
                            state <= la_pkg::MOVE_TO_POSITION;
                        end
                    end
                end
                la_pkg::MOVE_TO_POSITION: begin
                    acquire     <= 1'b1;
                    current_loc <= next_loc;
                    if (next_loc >= ctrl.trigger_loc) begin
                        state <= la_pkg::IN_POSITION;
                    end
                end
                la_pkg::IN_POSITION: begin
                    // window slides until the trigger, then stops popping
                    acquire <= 1'b1;
                    pop     <= ~trig;
                    if (trig) begin
                        state <= la_pkg::CAPTURING;
                    end
                end
                la_pkg::CAPTURING: begin
                    acquire <= 1'b1;
                    if (full) begin
                        acquire <= 1'b0;
                        state   <= la_pkg::CAPTURED;
                    end
                end
                la_pkg::CAPTURED: begin
                    if (stop_edge) begin
                        state <= la_pkg::IDLE;
                    end
                end
                default: state <= la_pkg::IDLE;
            endcase
        end
    end

    assign wr_en   = acquire & ~full;
    assign wr_addr = write_pointer[AW-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
        end else begin
            if (wr_en) begin
                write_pointer <= write_pointer + 1'b1;
            end
            // an empty window may still pop the sample written this cycle
            if (clear) begin
                read_pointer <= write_pointer;
            end else if (pop && (fill != '0 || wr_en)) begin
                read_pointer <= read_pointer + 1'b1;
            end
        end
    end

    assign ctrl.state        = state;
    assign ctrl.current_loc  = current_loc;
    assign ctrl.read_pointer = read_pointer[AW-1:0];

    a_fill_bound: assert property (@(posedge clk) disable iff (!rst_n)
        fill <= (AW+1)'(DEPTH))
        else $error("sample buffer fill count above depth");

    a_no_write_at_rest: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {la_pkg::IDLE, la_pkg::CAPTURED}) |-> !wr_en)
        else $error("sample write while idle or captured");

    // the trigger sample must land at logical index trigger_loc
    a_trigger_position: assert property (@(posedge clk) disable iff (!rst_n)
        (state == la_pkg::IN_POSITION && trig && ctrl.trigger_loc >= 0 &&
         ctrl.trigger_loc < DEPTH)
        |=> (wr_en && fill == ctrl.trigger_loc[AW:0]))
        else $error("trigger sample not stored at trigger_loc");

endmodule

//--- src/la_sample_ram.sv
`include "la_defs.svh"

module la_sample_ram (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [`LA_ADDR_WIDTH-1:0]  wr_addr,
    input  logic [`LA_PROBE_WIDTH-1:0] wr_data,
    input  logic [`LA_ADDR_WIDTH-1:0]  rd_addr,
    output logic [`LA_PROBE_WIDTH-1:0] rd_data
);

    localparam int DEPTH = `LA_SAMPLE_DEPTH;
    localparam int W     = `LA_PROBE_WIDTH;

    // circular sample store, one write and one read port
    logic [W-1:0] mem [DEPTH];

    // write port driven by the capture controller
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read for the host readback path
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- src/la_reg_file.sv
`include "la_defs.svh"

module la_reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`LA_REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [`LA_REG_DATA_WIDTH-1:0] reg_wdata,
    input  logic                          reg_write,
    input  logic                          reg_read,
    output logic [`LA_REG_DATA_WIDTH-1:0] reg_rdata,
    output logic                          reg_rvalid,
    la_ctrl_if.regs                       ctrl,
    output la_pkg::trig_mode_t            trig_mode,
    output logic [`LA_PROBE_WIDTH-1:0]    trig_mask,
    output logic [`LA_PROBE_WIDTH-1:0]    trig_value,
    output logic [`LA_ADDR_WIDTH-1:0]     ram_rd_addr,
    input  logic [`LA_PROBE_WIDTH-1:0]    ram_rd_data
);

    localparam int DW = `LA_REG_DATA_WIDTH;
    localparam int SW = $bits(la_pkg::cap_state_t);

    la_pkg::reg_addr_t         sel;
    la_pkg::reg_addr_t         rd_sel_q;
    logic                      start_q;
    logic                      stop_q;
    logic signed [DW-1:0]      trigger_loc_q;
    logic [`LA_ADDR_WIDTH-1:0] sample_index;
    logic [DW-1:0]             rd_mux;
    logic [DW-1:0]             rd_data_q;
    logic                      rd_pend;

    assign sel = la_pkg::reg_addr_t'(reg_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q       <= 1'b0;
            stop_q        <= 1'b0;
            trig_mode     <= la_pkg::TRIG_EQUAL;
            trig_mask     <= '0;
            trig_value    <= '0;
            trigger_loc_q <= '0;
            sample_index  <= '0;
        end else if (reg_write) begin
            case (sel)
                la_pkg::REG_CONTROL: begin
                    start_q <= reg_wdata[0];
                    stop_q  <= reg_wdata[1];
                end
                la_pkg::REG_TRIG_MODE:    trig_mode <= la_pkg::trig_mode_t'(reg_wdata[0]);
                la_pkg::REG_TRIG_MASK:    trig_mask <= reg_wdata[`LA_PROBE_WIDTH-1:0];
                la_pkg::REG_TRIG_VALUE:   trig_value <= reg_wdata[`LA_PROBE_WIDTH-1:0];
                la_pkg::REG_TRIG_LOC:     trigger_loc_q <= reg_wdata;
                la_pkg::REG_SAMPLE_INDEX: sample_index <= reg_wdata[`LA_ADDR_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // status packs the state in the low nibble, position above it
    always_comb begin
        case (sel)
            la_pkg::REG_CONTROL:      rd_mux = DW'({stop_q, start_q});
            la_pkg::REG_TRIG_MODE:    rd_mux = DW'(trig_mode);
            la_pkg::REG_TRIG_MASK:    rd_mux = DW'(trig_mask);
            la_pkg::REG_TRIG_VALUE:   rd_mux = DW'(trig_value);
            la_pkg::REG_TRIG_LOC:     rd_mux = trigger_loc_q;
            la_pkg::REG_STATUS:       rd_mux = {ctrl.current_loc[DW-SW-1:0], ctrl.state};
            la_pkg::REG_SAMPLE_INDEX: rd_mux = DW'(sample_index);
            default:                  rd_mux = '0;
        endcase
    end

    // logical index 0 is the oldest sample of the capture
    assign ram_rd_addr = ctrl.read_pointer + sample_index;

    // two-stage read, the second stage picks memory data when needed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend    <= 1'b0;
            reg_rvalid <= 1'b0;
        end else begin
            rd_pend    <= reg_read;
            reg_rvalid <= rd_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_read) begin
            rd_sel_q  <= sel;
            rd_data_q <= rd_mux;
        end
        if (rd_pend) begin
            if (rd_sel_q == la_pkg::REG_SAMPLE_DATA) begin
                reg_rdata <= DW'(ram_rd_data);
            end else begin
                reg_rdata <= rd_data_q;
            end
        end
    end

    assign ctrl.request_start = start_q;
    assign ctrl.request_stop  = stop_q;
    assign ctrl.trigger_loc   = trigger_loc_q;

    a_single_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pend |-> !reg_read)
        else $error("read strobe while a read is still pending");

endmodule

//--- src/logic_analyzer.sv
`include "la_defs.svh"

module logic_analyzer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`LA_PROBE_WIDTH-1:0]    probe,
    input  logic [`LA_REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [`LA_REG_DATA_WIDTH-1:0] reg_wdata,
    input  logic                          reg_write,
    input  logic                          reg_read,
    output logic [`LA_REG_DATA_WIDTH-1:0] reg_rdata,
    output logic                          reg_rvalid
);

    // trigger configuration
    la_pkg::trig_mode_t         trig_mode;
    logic [`LA_PROBE_WIDTH-1:0] trig_mask;
    logic [`LA_PROBE_WIDTH-1:0] trig_value;

    // sample stream and trigger
    logic                       trig;
    logic [`LA_PROBE_WIDTH-1:0] sample;

    // sample memory ports
    logic [`LA_ADDR_WIDTH-1:0]  wr_addr;
    logic                       wr_en;
    logic [`LA_ADDR_WIDTH-1:0]  ram_rd_addr;
    logic [`LA_PROBE_WIDTH-1:0] ram_rd_data;

    la_ctrl_if ctrl_bus ();

    la_reg_file u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_write   (reg_write),
        .reg_read    (reg_read),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .ctrl        (ctrl_bus.regs),
        .trig_mode   (trig_mode),
        .trig_mask   (trig_mask),
        .trig_value  (trig_value),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data)
    );

    la_trigger u_trigger (
        .clk        (clk),
        .rst_n      (rst_n),
        .probe      (probe),
        .trig_mode  (trig_mode),
        .trig_mask  (trig_mask),
        .trig_value (trig_value),
        .trig       (trig),
        .sample     (sample)
    );

    la_controller u_controller (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl_bus.ctrl),
        .trig    (trig),
        .wr_addr (wr_addr),
        .wr_en   (wr_en)
    );

    la_sample_ram u_sample_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (sample),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

endmodule

//--- test/tb_logic_analyzer.sv
`include "la_defs.svh"

module tb_logic_analyzer;

    localparam int DEPTH      = `LA_SAMPLE_DEPTH;
    localparam int AW         = `LA_ADDR_WIDTH;
    localparam int PW         = `LA_PROBE_WIDTH;
    localparam int DW         = `LA_REG_DATA_WIDTH;
    localparam int SW         = $bits(la_pkg::cap_state_t);
    localparam int CLK_PERIOD = 4;

    // equality trigger looks at the low byte and so matches within 256 cycles
    localparam logic [PW-1:0] EQ_MASK = 16'h00ff;

    // cycle budget of one capture covers pre-trigger fill, trigger wait and readback
    localparam int TRIG_WAIT       = 512;
    localparam int READBACK        = DEPTH * 8;
    localparam int CAPTURE_CYCLES  = DEPTH + TRIG_WAIT + READBACK;
    localparam int WATCHDOG_CYCLES = 4 * CAPTURE_CYCLES + 64;
    localparam int POLL_LIMIT      = (DEPTH + TRIG_WAIT) / 2;
    localparam int RVALID_LIMIT    = 8;

    logic                          clk;
    logic                          rst_n;
    logic [PW-1:0]                 probe;
    logic [`LA_REG_ADDR_WIDTH-1:0] reg_addr;
    logic [DW-1:0]                 reg_wdata;
    logic                          reg_write;
    logic                          reg_read;
    logic [DW-1:0]                 reg_rdata;
    logic                          reg_rvalid;

    logic [31:0]   lfsr_state;
    logic [PW-1:0] samples [DEPTH];

    logic_analyzer UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .probe      (probe),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_write  (reg_write),
        .reg_read   (reg_read),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // free-running probe counter
    always @(negedge clk) begin
        probe = probe + 1'b1;
    end

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [PW-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[PW-2:0], lfsr_state[0]};
        end
    endtask

    task automatic write_reg(input la_pkg::reg_addr_t addr, input logic [DW-1:0] data);
        @(negedge clk);
        reg_addr  = addr;
        reg_wdata = data;
        reg_write = 1'b1;
        @(negedge clk);
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input la_pkg::reg_addr_t addr, output logic [DW-1:0] data);
        int waited;
        @(negedge clk);
        reg_addr = addr;
        reg_read = 1'b1;
        @(negedge clk);
        reg_read = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!reg_rvalid && waited < RVALID_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!reg_rvalid) begin
            abort_run($sformatf("no reg_rvalid after reading register %s", addr.name()));
        end else begin
            data = reg_rdata;
        end
    endtask

    task automatic wait_for_state(input la_pkg::cap_state_t target, input int max_polls);
        logic [DW-1:0] status;
        int            polls;
        polls = 0;
        read_reg(la_pkg::REG_STATUS, status);
        while (status[SW-1:0] != target && polls < max_polls) begin
            read_reg(la_pkg::REG_STATUS, status);
            polls++;
        end
        if (status[SW-1:0] != target) begin
            abort_run($sformatf("capture never reached state %s", target.name()));
        end
    endtask

    // readback oldest first and check the stream has no gap
    task automatic read_and_check_samples();
        for (int i = 0; i < DEPTH; i++) begin
            write_reg(la_pkg::REG_SAMPLE_INDEX, DW'(i));
            read_reg(la_pkg::REG_SAMPLE_DATA, samples[i]);
        end
        for (int i = 1; i < DEPTH; i++) begin
            assert (samples[i] == PW'(samples[i-1] + 1'b1))
                else report_error($sformatf("sample %0d is %h, expected %h", i, samples[i],
                                            PW'(samples[i-1] + 1'b1)));
        end
    endtask

    task automatic run_capture(input la_pkg::trig_mode_t mode, input logic [PW-1:0] mask,
                               input logic [PW-1:0] value, input int loc);
        write_reg(la_pkg::REG_TRIG_MODE, DW'(mode));
        write_reg(la_pkg::REG_TRIG_MASK, mask);
        write_reg(la_pkg::REG_TRIG_VALUE, value);
        write_reg(la_pkg::REG_TRIG_LOC, DW'(loc));
        // start rises here and stop drops
        write_reg(la_pkg::REG_CONTROL, 16'h0001);
        wait_for_state(la_pkg::CAPTURED, POLL_LIMIT);
        read_and_check_samples();
    endtask

    task automatic stop_and_check_idle();
        logic [DW-1:0] status;
        write_reg(la_pkg::REG_CONTROL, 16'h0002);
        read_reg(la_pkg::REG_STATUS, status);
        assert (status[SW-1:0] == la_pkg::IDLE)
            else report_error($sformatf("status %h after stop, expected state IDLE", status));
    endtask

    task automatic check_equal_trigger(input int loc, input logic [PW-1:0] value);
        assert ((samples[loc] & EQ_MASK) == (value & EQ_MASK))
            else report_error($sformatf("sample %0d is %h, expected %h under mask %h",
                                        loc, samples[loc], value, EQ_MASK));
    endtask

    a_rvalid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        reg_read |-> ##2 reg_rvalid)
        else report_error("reg_rvalid missing 2 cycles after a read strobe");

    a_rvalid_has_read: assert property (@(posedge clk) disable iff (!rst_n)
        reg_rvalid |-> $past(reg_read, 2))
        else report_error("reg_rvalid without a read strobe 2 cycles before");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        logic [DW-1:0] status;
        logic [PW-1:0] value;
        logic [PW-1:0] rnd;
        int            loc;
        int            k;
        int            locs [2];

        rst_n      = 1'b0;
        probe      = '0;
        reg_addr   = '0;
        reg_wdata  = '0;
        reg_write  = 1'b0;
        reg_read   = 1'b0;
        lfsr_state = 32'hdf02_997b;
        locs[0]    = 0;
        locs[1]    = DEPTH - 1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle with position zero after reset
        read_reg(la_pkg::REG_STATUS, status);
        assert (status == DW'(la_pkg::IDLE))
            else report_error($sformatf("status %h after reset, expected 0000", status));
        read_reg(la_pkg::REG_TRIG_LOC, status);
        assert (status == '0)
            else report_error($sformatf("trigger_loc %h after reset, expected 0000", status));

        // equality trigger with a random value and position
        draw_bits(PW, value);
        draw_bits(AW, rnd);
        loc = 1 + int'(rnd) % (DEPTH - 2);
        run_capture(la_pkg::TRIG_EQUAL, EQ_MASK, value, loc);
        check_equal_trigger(loc, value);
        stop_and_check_idle();

        // a rising edge on bit k means the lower bits just wrapped to zero
        draw_bits(3, rnd);
        k = int'(rnd);
        draw_bits(AW, rnd);
        loc = int'(rnd);
        run_capture(la_pkg::TRIG_RISING, PW'(1) << k, '0, loc);
        assert (samples[loc][k] == 1'b1 && (samples[loc] & ((PW'(1) << k) - 1'b1)) == '0)
            else report_error($sformatf("sample %0d is %h, expected bit %0d set, lower bits 0",
                                        loc, samples[loc], k));
        stop_and_check_idle();

        // both ends of the trigger position range
        foreach (locs[i]) begin
            draw_bits(PW, value);
            run_capture(la_pkg::TRIG_EQUAL, EQ_MASK, value, locs[i]);
            check_equal_trigger(locs[i], value);
            stop_and_check_idle();
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- logic_analyzer.f
+incdir+include
src/la_pkg.sv
src/la_ctrl_if.sv
src/la_trigger.sv
src/la_controller.sv
src/la_sample_ram.sv
src/la_reg_file.sv
src/logic_analyzer.sv
test/tb_logic_analyzer.sv
